// ==== design/conv_config_loader.sv ====
`default_nettype none

module conv_config_loader (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               load_start,
	input  logic [31:0]                        data_mem,
	input  logic                               mapped_data_valid,
	output logic [31:0]                        cfg_address,
	output logic                               load_done,
	output logic [conv_pkg::dim_bits-1:0]      image_width,
	output logic [conv_pkg::dim_bits-1:0]      image_height,
	output logic [31:0]                        start_address,
	output logic [31:0]                        result_address,
	output logic [conv_pkg::window_bits-1:0]   filter
);
	import conv_pkg::*;

	logic [2:0] step;
	logic       busy;
	cfg_word_u  word;

	assign word = data_mem;

	always_comb begin
		case (step)
			3'd0:    cfg_address = addr_dims;
			3'd1:    cfg_address = addr_start;
			3'd2:    cfg_address = addr_filter;
			3'd3:    cfg_address = addr_filter + 32'd4;
			3'd4:    cfg_address = addr_filter + 32'd8;
			default: cfg_address = addr_result;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			step <= '0;
			load_done <= 1'b0;
		end else begin
			load_done <= 1'b0;
			if (!busy) begin
				busy <= load_start;
				step <= '0;
			end else if (mapped_data_valid) begin
				if (step == 3'd5) begin // result base is the last word
					busy <= 1'b0;
					step <= '0;
					load_done <= 1'b1;
				end else begin
					step <= step + 1'b1;
				end
			end
		end
	end

	// job settings, written once per load
	always_ff @(posedge clk) begin
		if (busy && mapped_data_valid) begin
			case (step)
				3'd0: begin
					image_width <= word.dims.width;
					image_height <= word.dims.height;
				end
				3'd1:
					start_address <= word.raw;
				3'd2:
					for (int k = 0; k < 4; k++)
						filter[k*tap_bits +: tap_bits] <= word.taps[k];
				3'd3:
					for (int k = 0; k < 4; k++)
						filter[(k+4)*tap_bits +: tap_bits] <= word.taps[k];
				3'd4:
					filter[8*tap_bits +: tap_bits] <= word.taps[0]; // upper bytes unused
				default:
					result_address <= word.raw;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/conv_controller.sv ====
`default_nettype none

module conv_controller (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [31:0]                     data_mem,
	input  logic                            mapped_data_valid,
	input  logic [31:0]                     cfg_address,
	input  logic                            load_done,
	input  logic [conv_pkg::dim_bits-1:0]   image_width,
	input  logic [conv_pkg::dim_bits-1:0]   image_height,
	input  logic [31:0]                     start_address,
	input  logic [31:0]                     result_address,
	input  logic                            pixel_valid,
	input  logic                            result_valid,
	output logic [31:0]                     address_mem,
	output logic                            load_start,
	output logic                            request_read,
	output logic [31:0]                     read_address,
	output logic [conv_pkg::dim_bits-1:0]   read_size,
	output logic                            shift_cols,
	output logic [conv_pkg::col_bits-1:0]   col_address,
	output logic                            window_mark,
	output logic [31:0]                     write_address,
	output logic                            done
);
	import conv_pkg::*;

	logic [state_bits-1:0] state;
	logic [state_bits-1:0] state_next;
	logic [col_bits-1:0]   col;
	logic [dim_bits-1:0]   row;
	logic [31:0]           result_count;
	logic [31:0]           total_results;
	logic                  start_seen;
	logic                  config_ready;
	logic                  last_col;
	logic                  last_row;
	logic                  last_result;

	assign start_seen = mapped_data_valid && (data_mem == 32'd1);
	assign config_ready = (state == st_load_config) && load_done;
	assign last_col = (dim_bits'(col) == image_width - 1'b1);
	assign last_row = (row == image_height - 1'b1);
	assign total_results = (32'(image_width) - 32'd2) * (32'(image_height) - 32'd2);
	assign last_result = result_valid && (result_count == total_results - 32'd1);

	assign address_mem = (state == st_load_config) ? cfg_address : addr_startsig;
	assign load_start = (state == st_idle) && start_seen;
	assign request_read = (state == st_row_request);
	assign read_size = image_width;
	assign shift_cols = (state == st_row_stream) && pixel_valid;
	assign col_address = col;
	assign window_mark = shift_cols && (row >= 2) && (col >= 2); // valid conv only
	assign done = (state == st_done);

	always_comb begin
		state_next = state;
		case (state)
			st_idle:
				if (start_seen)
					state_next = st_load_config;
			st_load_config:
				if (load_done)
					state_next = st_row_request;
			st_row_request:
				state_next = st_row_stream;
			st_row_stream:
				if (pixel_valid && last_col)
					state_next = last_row ? st_drain : st_row_request;
			st_drain:
				if (last_result)
					state_next = st_done;
			st_done:
				state_next = st_idle;
			default:
				state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= st_idle;
		else
			state <= state_next;
	end

	// pixel position and row source address
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col <= '0;
			row <= '0;
			read_address <= '0;
		end else if (config_ready) begin
			col <= '0;
			row <= '0;
			read_address <= start_address;
		end else if (shift_cols) begin
			if (last_col) begin
				col <= '0;
				row <= row + 1'b1;
				read_address <= read_address + 32'(image_width); // next row
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// one write address per result
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result_count <= '0;
			write_address <= '0;
		end else if (config_ready) begin
			result_count <= '0;
			write_address <= result_address;
		end else if (result_valid) begin
			result_count <= result_count + 32'd1;
			write_address <= write_address + 32'(result_stride);
		end
	end

endmodule

`default_nettype wire

// ==== design/conv_mac.sv ====
`default_nettype none

module conv_mac (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic [conv_pkg::window_bits-1:0]      window,
	input  logic [conv_pkg::window_bits-1:0]      filter,
	input  logic                                  window_valid,
	output logic signed [conv_pkg::result_bits-1:0] result,
	output logic                                  result_valid
);
	import conv_pkg::*;

	logic signed [pixel_bits+tap_bits:0] prod [window_size];
	logic                                prod_valid;
	logic signed [result_bits-1:0]       sum;

	// stage one, unsigned pixel times signed tap
	always_ff @(posedge clk) begin
		if (window_valid) begin
			for (int k = 0; k < window_size; k++)
				prod[k] <= $signed({1'b0, window[k*pixel_bits +: pixel_bits]}) *
					$signed(filter[k*tap_bits +: tap_bits]);
		end
	end

	always_comb begin
		sum = '0;
		for (int k = 0; k < window_size; k++)
			sum = sum + prod[k]; // sign extended
	end

	// stage two
	always_ff @(posedge clk) begin
		if (prod_valid)
			result <= sum;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prod_valid <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			prod_valid <= window_valid;
			result_valid <= prod_valid;
		end
	end

endmodule

`default_nettype wire

// ==== design/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

	// register window
	localparam logic [31:0] addr_startsig = 32'h1000_0120;
	localparam logic [31:0] addr_dims     = 32'h1000_0000;
	localparam logic [31:0] addr_start    = 32'h1000_0020;
	localparam logic [31:0] addr_filter   = 32'h1000_0040; // three words, step 4
	localparam logic [31:0] addr_result   = 32'h1000_0100;

	localparam int max_width     = 64;
	localparam int col_bits      = 6;
	localparam int dim_bits      = 16;
	localparam int pixel_bits    = 8;
	localparam int tap_bits      = 8;
	localparam int window_size   = 9;
	localparam int window_bits   = 72; // element 0 is top-left
	localparam int result_bits   = 20;
	localparam int result_stride = 4;

	// controller states
	localparam int state_bits = 3;
	localparam logic [state_bits-1:0] st_idle        = 3'd0;
	localparam logic [state_bits-1:0] st_load_config = 3'd1;
	localparam logic [state_bits-1:0] st_row_request = 3'd2;
	localparam logic [state_bits-1:0] st_row_stream  = 3'd3;
	localparam logic [state_bits-1:0] st_drain       = 3'd4;
	localparam logic [state_bits-1:0] st_done        = 3'd5;

	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [dim_bits-1:0] height;
			logic [dim_bits-1:0] width;
		} dims;
		logic signed [3:0][tap_bits-1:0] taps; // tap n in byte n
	} cfg_word_u;

endpackage

`default_nettype wire

// ==== design/conv_top.sv ====
`default_nettype none

module conv_top (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic [31:0]                             data_mem,
	input  logic                                    mapped_data_valid,
	input  logic [conv_pkg::pixel_bits-1:0]         pixel_data,
	input  logic                                    pixel_valid,
	output logic [31:0]                             address_mem,
	output logic                                    request_read,
	output logic [31:0]                             read_address,
	output logic [conv_pkg::dim_bits-1:0]           read_size,
	output logic signed [conv_pkg::result_bits-1:0] result,
	output logic                                    result_valid,
	output logic [31:0]                             write_address,
	output logic                                    done
);
	import conv_pkg::*;

	logic                   load_start;
	logic                   load_done;
	logic [31:0]            cfg_address;
	logic [dim_bits-1:0]    image_width;
	logic [dim_bits-1:0]    image_height;
	logic [31:0]            start_address;
	logic [31:0]            result_address;
	logic [window_bits-1:0] filter;
	logic                   shift_cols;
	logic [col_bits-1:0]    col_address;
	logic                   window_mark;
	logic [window_bits-1:0] window;
	logic                   window_valid;

	conv_config_loader u_loader (
		.clk               (clk),
		.rst_n             (rst_n),
		.load_start        (load_start),
		.data_mem          (data_mem),
		.mapped_data_valid (mapped_data_valid),
		.cfg_address       (cfg_address),
		.load_done         (load_done),
		.image_width       (image_width),
		.image_height      (image_height),
		.start_address     (start_address),
		.result_address    (result_address),
		.filter            (filter)
	);

	conv_controller u_controller (
		.clk               (clk),
		.rst_n             (rst_n),
		.data_mem          (data_mem),
		.mapped_data_valid (mapped_data_valid),
		.cfg_address       (cfg_address),
		.load_done         (load_done),
		.image_width       (image_width),
		.image_height      (image_height),
		.start_address     (start_address),
		.result_address    (result_address),
		.pixel_valid       (pixel_valid),
		.result_valid      (result_valid),
		.address_mem       (address_mem),
		.load_start        (load_start),
		.request_read      (request_read),
		.read_address      (read_address),
		.read_size         (read_size),
		.shift_cols        (shift_cols),
		.col_address       (col_address),
		.window_mark       (window_mark),
		.write_address     (write_address),
		.done              (done)
	);

	line_window u_window (
		.clk          (clk),
		.rst_n        (rst_n),
		.shift_cols   (shift_cols),
		.col_address  (col_address),
		.pixel_data   (pixel_data),
		.window_mark  (window_mark),
		.window       (window),
		.window_valid (window_valid)
	);

	conv_mac u_mac (
		.clk          (clk),
		.rst_n        (rst_n),
		.window       (window),
		.filter       (filter),
		.window_valid (window_valid),
		.result       (result),
		.result_valid (result_valid)
	);

endmodule

`default_nettype wire

// ==== design/line_window.sv ====
`default_nettype none

module line_window (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              shift_cols,
	input  logic [conv_pkg::col_bits-1:0]     col_address,
	input  logic [conv_pkg::pixel_bits-1:0]   pixel_data,
	input  logic                              window_mark,
	output logic [conv_pkg::window_bits-1:0]  window,
	output logic                              window_valid
);
	import conv_pkg::*;

	logic [pixel_bits-1:0] line_old [max_width]; // two rows back
	logic [pixel_bits-1:0] line_new [max_width]; // previous row
	logic [pixel_bits-1:0] old_pixel;
	logic [pixel_bits-1:0] new_pixel;

	assign old_pixel = line_old[col_address];
	assign new_pixel = line_new[col_address];

	always_ff @(posedge clk) begin
		if (shift_cols) begin
			line_old[col_address] <= new_pixel; // rows move up by one
			line_new[col_address] <= pixel_data;
		end
	end

	always_ff @(posedge clk) begin
		if (shift_cols) begin
			for (int r = 0; r < 3; r++) begin
				window[(3*r)*pixel_bits +: pixel_bits] <=
					window[(3*r+1)*pixel_bits +: pixel_bits];
				window[(3*r+1)*pixel_bits +: pixel_bits] <=
					window[(3*r+2)*pixel_bits +: pixel_bits];
			end
			window[2*pixel_bits +: pixel_bits] <= old_pixel; // new right column
			window[5*pixel_bits +: pixel_bits] <= new_pixel;
			window[8*pixel_bits +: pixel_bits] <= pixel_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			window_valid <= 1'b0;
		else
			window_valid <= window_mark;
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the conv_tb simulation with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f src.f --top-module conv_tb -o conv_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi
./obj_dir/conv_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if grep -q "Testbench failed" sim.log; then
	exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0

// ==== src.f ====
design/conv_pkg.sv
design/conv_config_loader.sv
design/conv_controller.sv
design/line_window.sv
design/conv_mac.sv
design/conv_top.sv
test/clock_gen.sv
test/conv_tb.sv

// ==== test/clock_gen.sv ====
`default_nettype none

module clock_gen (
	output logic clk,
	output logic rst_n
);
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
	end
endmodule

`default_nettype wire

// ==== test/conv_tb.sv ====
`default_nettype none

module conv_tb;
	import conv_pkg::*;

	logic               clk;
	logic               rst_n;
	logic [31:0]        data_mem = '0;
	logic               mapped_data_valid = 1'b0;
	logic [7:0]         pixel_data = '0;
	logic               pixel_valid = 1'b0;
	logic [31:0]        address_mem;
	logic               request_read;
	logic [31:0]        read_address;
	logic [15:0]        read_size;
	logic signed [19:0] result;
	logic               result_valid;
	logic [31:0]        write_address;
	logic               done;

	logic [7:0]         img [4096]; // byte offset from the source address
	logic signed [7:0]  taps [9];
	int                 reg_width = 3;
	int                 reg_height = 3;
	logic [31:0]        reg_src = '0;
	logic [31:0]        reg_dst = '0;
	logic [31:0]        start_value = 32'd1;
	int                 start_req = 0; // start word pending while req != ack
	int                 start_ack = 0;
	int                 gap_pct = 0;
	int                 seed = 32'h3211;
	bit                 cfg_busy = 1'b0;
	int                 cfg_wait = 0;
	logic [31:0]        cfg_addr = '0;
	int                 pix_addr = 0;
	int                 pix_left = 0;
	int                 exp_res [$];
	logic [31:0]        exp_addr [$];
	int                 req_total = 0;
	int                 rows_seen = 0; // row requests in the current job
	int                 res_total = 0;
	int                 done_total = 0;
	int                 cycle_count = 0;
	int                 last_rv_cycle = 0;
	int                 errors = 0;
	int                 tests = 0;
	int                 failed = 0;

	clock_gen u_clk (.clk(clk), .rst_n(rst_n));

	conv_top u_dut (
		.clk               (clk),
		.rst_n             (rst_n),
		.data_mem          (data_mem),
		.mapped_data_valid (mapped_data_valid),
		.pixel_data        (pixel_data),
		.pixel_valid       (pixel_valid),
		.address_mem       (address_mem),
		.request_read      (request_read),
		.read_address      (read_address),
		.read_size         (read_size),
		.result            (result),
		.result_valid      (result_valid),
		.write_address     (write_address),
		.done              (done)
	);

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		$display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, want);
		errors++;
	endtask

	task automatic report_problem(input string what);
		$display("error at %0t: %s", $time, what);
		errors++;
	endtask

	function automatic logic [31:0] register_word(input logic [31:0] addr);
		case (addr)
			addr_dims:           return {16'(reg_height), 16'(reg_width)};
			addr_start:          return reg_src;
			addr_filter:         return {taps[3], taps[2], taps[1], taps[0]};
			addr_filter + 32'd4: return {taps[7], taps[6], taps[5], taps[4]};
			addr_filter + 32'd8: return {24'd0, taps[8]};
			addr_result:         return reg_dst;
			default:             return 32'hdead_beef;
		endcase
	endfunction

	// register window, one read at a time
	always @(posedge clk) begin
		mapped_data_valid <= 1'b0;
		if (!cfg_busy && !mapped_data_valid && rst_n) begin // address settles after a valid
			cfg_addr = address_mem;
			cfg_wait = 1 + ($unsigned($random(seed)) % 4);
			cfg_busy = 1'b1;
		end else if (cfg_busy) begin
			cfg_wait = cfg_wait - 1;
			if (cfg_wait == 0) begin
				cfg_busy = 1'b0;
				mapped_data_valid <= 1'b1;
				if (cfg_addr == addr_startsig) begin
					data_mem <= (start_req != start_ack) ? start_value : 32'd0;
					start_ack = start_req; // start word clears on read
				end else begin
					data_mem <= register_word(cfg_addr);
				end
			end
		end
	end

	// row stream with random idle beats
	always @(posedge clk) begin
		if (request_read) begin
			pix_addr = read_address - reg_src;
			pix_left = read_size;
			pixel_valid <= 1'b0;
		end else if (pix_left > 0 && ($unsigned($random(seed)) % 100) >= gap_pct) begin
			pixel_data <= img[pix_addr];
			pixel_valid <= 1'b1;
			pix_addr = pix_addr + 1;
			pix_left = pix_left - 1;
		end else begin
			pixel_valid <= 1'b0;
		end
	end

	always @(negedge clk) begin : monitor
		int          want;
		logic [31:0] want_addr;
		if (rst_n) begin
			cycle_count++;
			if (request_read) begin
				if (read_address !== reg_src + 32'(rows_seen * reg_width))
					report_mismatch("read_address", read_address,
						reg_src + 32'(rows_seen * reg_width));
				if (read_size !== 16'(reg_width))
					report_mismatch("read_size", 32'(read_size), 32'(reg_width));
				rows_seen++;
				req_total++;
			end
			if (result_valid) begin
				if (exp_res.size() == 0) begin
					report_problem("result_valid with no result expected");
				end else begin
					want = exp_res.pop_front();
					want_addr = exp_addr.pop_front();
					if (result !== 20'(want))
						report_mismatch("result", 32'(result), 32'(want));
					if (write_address !== want_addr)
						report_mismatch("write_address", write_address, want_addr);
				end
				res_total++;
				last_rv_cycle = cycle_count;
			end
			if (done) begin
				if (cycle_count != last_rv_cycle + 1)
					report_problem("done is not one cycle after the last result");
				if (exp_res.size() != 0)
					report_problem("done while results are still missing");
				done_total++;
			end
		end
	end

	task automatic fill_image(input int w, input int h);
		for (int i = 0; i < w * h; i++)
			img[i] = 8'($random(seed));
	endtask

	task automatic random_taps();
		for (int k = 0; k < 9; k++)
			taps[k] = 8'($random(seed) % 100);
	endtask

	// valid 3x3 convolution, raster order
	task automatic build_reference(input int w, input int h);
		int s;
		exp_res.delete();
		exp_addr.delete();
		for (int r = 0; r < h - 2; r++) begin
			for (int c = 0; c < w - 2; c++) begin
				s = 0;
				for (int k = 0; k < 9; k++)
					s += int'(img[(r + k / 3) * w + c + k % 3]) * int'(taps[k]);
				exp_addr.push_back(reg_dst + 32'(exp_res.size() * result_stride));
				exp_res.push_back(s);
			end
		end
	endtask

	task automatic run_job(input int w, input int h, input int gap);
		int req_base;
		int res_base;
		int done_base;
		int cycles;
		reg_width = w;
		reg_height = h;
		gap_pct = gap;
		reg_src = 32'h0010_0000 + 32'(w * h);
		reg_dst = 32'h0020_0000 + 32'(w * 256);
		build_reference(w, h);
		req_base = req_total;
		res_base = res_total;
		done_base = done_total;
		rows_seen = 0;
		start_value = 32'd1;
		start_req++;
		cycles = 0;
		while (done_total == done_base && cycles < 20000) begin
			@(posedge clk);
			cycles++;
		end
		if (done_total == done_base) begin
			$display("timeout: no done pulse for the %0dx%0d job", w, h);
			$display("Testbench failed");
			$finish;
		end
		repeat (8) @(posedge clk); // room for a second done pulse
		if (done_total - done_base != 1)
			report_mismatch("done pulses", 32'(done_total - done_base), 32'd1);
		if (res_total - res_base != (w - 2) * (h - 2))
			report_mismatch("result count", 32'(res_total - res_base), 32'((w - 2) * (h - 2)));
		if (req_total - req_base != h)
			report_mismatch("request_read count", 32'(req_total - req_base), 32'(h));
		if (address_mem !== addr_startsig)
			report_mismatch("address_mem", address_mem, addr_startsig);
	endtask

	task automatic end_test(input string name, input int errors_before);
		tests++;
		if (errors == errors_before) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			failed++;
			$display("test %0d %s: %0d errors", tests, name, errors - errors_before);
		end
	endtask

	task automatic test_row_addressing();
		int e0;
		e0 = errors;
		fill_image(5, 4);
		random_taps();
		run_job(5, 4, 30);
		end_test("config and row addressing", e0);
	endtask

	task automatic test_identity();
		int e0;
		e0 = errors;
		fill_image(3, 3);
		for (int k = 0; k < 9; k++)
			taps[k] = (k == 4) ? 8'sd1 : 8'sd0; // centre tap only
		run_job(3, 3, 20);
		end_test("identity filter 3x3", e0);
	endtask

	task automatic test_random_filter();
		int e0;
		e0 = errors;
		fill_image(8, 6);
		random_taps();
		taps[0] = -8'sd128;
		taps[7] = -8'sd5;
		run_job(8, 6, 30);
		end_test("random image and filter 8x6", e0);
	endtask

	task automatic test_pixel_pacing();
		int e0;
		e0 = errors;
		fill_image(8, 6);
		random_taps();
		run_job(8, 6, 0);
		run_job(8, 6, 80); // same image, sparse beats
		end_test("pixel pacing", e0);
	endtask

	task automatic test_back_to_back();
		int e0;
		e0 = errors;
		fill_image(64, 3);
		random_taps();
		run_job(64, 3, 25);
		fill_image(4, 4);
		random_taps();
		run_job(4, 4, 25);
		end_test("max width then back-to-back job", e0);
	endtask

	task automatic test_no_spurious_start();
		int e0;
		int req_base;
		int res_base;
		int done_base;
		int cycles;
		e0 = errors;
		req_base = req_total;
		res_base = res_total;
		done_base = done_total;
		start_value = 32'd2;
		start_req++;
		cycles = 0;
		while (cycles < 300) begin
			@(posedge clk);
			cycles++;
		end
		if (start_ack != start_req)
			report_problem("start word was never polled");
		if (req_total != req_base || res_total != res_base || done_total != done_base)
			report_problem("DUT started a job on a start word other than 1");
		end_test("no spurious start", e0);
	endtask

	initial begin
		int cycles;
		cycles = 0;
		while (rst_n !== 1'b1 && cycles < 50) begin
			@(posedge clk);
			cycles++;
		end
		if (rst_n !== 1'b1) begin
			$display("timeout: reset never released");
			$display("Testbench failed");
			$finish;
		end
		@(negedge clk);
		if (address_mem !== addr_startsig)
			report_mismatch("address_mem", address_mem, addr_startsig);
		if (done !== 1'b0 || request_read !== 1'b0 || result_valid !== 1'b0 ||
				u_dut.shift_cols !== 1'b0 || u_dut.load_start !== 1'b0)
			report_problem("control output not low after reset");
		test_row_addressing();
		test_identity();
		test_random_filter();
		test_pixel_pacing();
		test_back_to_back();
		test_no_spurious_start();
		$display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire
